//--- id_macros.svh
`ifndef ID_MACROS_SVH
`define ID_MACROS_SVH

// datapath sizes
`define ID_XLEN      32
`define ID_REG_AW    5
`define ID_NUM_REGS  32
`define ID_ALU_OP_W  12

// instruction field positions
`define ID_RD_F      4:0
`define ID_RJ_F      9:5
`define ID_RK_F      14:10
`define ID_I12_F     21:10
`define ID_I16_F     25:10
`define ID_I20_F     24:5
// offs26 is stored split, upper ten bits in the low field
`define ID_I26_HI_F  9:0
`define ID_I26_LO_F  25:10

`endif

//--- id_pkg.sv
`include "id_macros.svh"

package id_pkg;

    typedef logic [`ID_XLEN-1:0]     word_t;
    typedef logic [`ID_REG_AW-1:0]   reg_addr_t;
    typedef logic [`ID_ALU_OP_W-1:0] alu_op_t;

    // bit index of each operation inside alu_op_t
    typedef enum int {
        alu_add  = 0,
        alu_sub  = 1,
        alu_slt  = 2,
        alu_sltu = 3,
        alu_and  = 4,
        alu_nor  = 5,
        alu_or   = 6,
        alu_xor  = 7,
        alu_sll  = 8,
        alu_srl  = 9,
        alu_sra  = 10,
        alu_lui  = 11
    } alu_bit_e;

    typedef enum logic [3:0] {
        mem_none,
        mem_ld_b,
        mem_ld_h,
        mem_ld_w,
        mem_ld_bu,
        mem_ld_hu,
        mem_st_b,
        mem_st_h,
        mem_st_w
    } mem_op_t;

    typedef enum logic [3:0] {
        br_none,
        br_beq,
        br_bne,
        br_blt,
        br_bge,
        br_bltu,
        br_bgeu,
        br_b,
        br_bl,
        br_jirl
    } br_kind_t;

endpackage

//--- inst_decoder.sv
`timescale 1ns/1ns
`include "id_macros.svh"

module inst_decoder (
    input  id_pkg::word_t     inst,
    output id_pkg::alu_op_t   alu_op,
    output id_pkg::mem_op_t   mem_op,
    output id_pkg::br_kind_t  br_kind,
    output logic              src1_is_pc,
    output logic              src2_is_imm,
    output logic              need_r1,
    output logic              need_r2,
    output logic              rf_we,
    output id_pkg::reg_addr_t rj,
    output id_pkg::reg_addr_t raddr2,
    output id_pkg::reg_addr_t dest,
    output id_pkg::word_t     imm,
    output id_pkg::word_t     br_offs
);
    wire [5:0]  op_31_26 = inst[31:26];
    wire [3:0]  op_25_22 = inst[25:22];
    wire [1:0]  op_21_20 = inst[21:20];
    wire [4:0]  op_19_15 = inst[19:15];
    wire [4:0]  rd       = inst[`ID_RD_F];
    wire [4:0]  rk       = inst[`ID_RK_F];
    wire [11:0] i12      = inst[`ID_I12_F];
    wire [15:0] i16      = inst[`ID_I16_F];
    wire [19:0] i20      = inst[`ID_I20_F];
    wire [25:0] i26      = {inst[`ID_I26_HI_F], inst[`ID_I26_LO_F]};

    // 3-register and shift-immediate groups share the upper opcode bits
    wire grp_3r  = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    wire grp_shi = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);
    wire grp_2ri = (op_31_26 == 6'h00);
    wire grp_mem = (op_31_26 == 6'h0a);

    wire inst_add   = grp_3r && (op_19_15 == 5'h00);
    wire inst_sub   = grp_3r && (op_19_15 == 5'h02);
    wire inst_slt   = grp_3r && (op_19_15 == 5'h04);
    wire inst_sltu  = grp_3r && (op_19_15 == 5'h05);
    wire inst_nor   = grp_3r && (op_19_15 == 5'h08);
    wire inst_and   = grp_3r && (op_19_15 == 5'h09);
    wire inst_or    = grp_3r && (op_19_15 == 5'h0a);
    wire inst_xor   = grp_3r && (op_19_15 == 5'h0b);
    wire inst_sll   = grp_3r && (op_19_15 == 5'h0e);
    wire inst_srl   = grp_3r && (op_19_15 == 5'h0f);
    wire inst_sra   = grp_3r && (op_19_15 == 5'h10);
    wire inst_slli  = grp_shi && (op_19_15 == 5'h01);
    wire inst_srli  = grp_shi && (op_19_15 == 5'h09);
    wire inst_srai  = grp_shi && (op_19_15 == 5'h11);
    wire inst_slti  = grp_2ri && (op_25_22 == 4'h8);
    wire inst_sltui = grp_2ri && (op_25_22 == 4'h9);
    wire inst_addi  = grp_2ri && (op_25_22 == 4'ha);
    wire inst_andi  = grp_2ri && (op_25_22 == 4'hd);
    wire inst_ori   = grp_2ri && (op_25_22 == 4'he);
    wire inst_xori  = grp_2ri && (op_25_22 == 4'hf);
    wire inst_lu12i = (op_31_26 == 6'h05) && !inst[25];
    wire inst_pcadd = (op_31_26 == 6'h07) && !inst[25];
    wire inst_ld_b  = grp_mem && (op_25_22 == 4'h0);
    wire inst_ld_h  = grp_mem && (op_25_22 == 4'h1);
    wire inst_ld_w  = grp_mem && (op_25_22 == 4'h2);
    wire inst_st_b  = grp_mem && (op_25_22 == 4'h4);
    wire inst_st_h  = grp_mem && (op_25_22 == 4'h5);
    wire inst_st_w  = grp_mem && (op_25_22 == 4'h6);
    wire inst_ld_bu = grp_mem && (op_25_22 == 4'h8);
    wire inst_ld_hu = grp_mem && (op_25_22 == 4'h9);
    wire inst_jirl  = (op_31_26 == 6'h13);
    wire inst_b     = (op_31_26 == 6'h14);
    wire inst_bl    = (op_31_26 == 6'h15);
    wire inst_beq   = (op_31_26 == 6'h16);
    wire inst_bne   = (op_31_26 == 6'h17);
    wire inst_blt   = (op_31_26 == 6'h18);
    wire inst_bge   = (op_31_26 == 6'h19);
    wire inst_bltu  = (op_31_26 == 6'h1a);
    wire inst_bgeu  = (op_31_26 == 6'h1b);

    wire is_load  = inst_ld_b | inst_ld_h | inst_ld_w | inst_ld_bu | inst_ld_hu;
    wire is_store = inst_st_b | inst_st_h | inst_st_w;
    wire is_cbr   = inst_beq | inst_bne | inst_blt | inst_bge | inst_bltu | inst_bgeu;
    wire is_3r    = inst_add | inst_sub | inst_slt | inst_sltu | inst_nor | inst_and
                  | inst_or | inst_xor | inst_sll | inst_srl | inst_sra;
    wire is_ri    = inst_slli | inst_srli | inst_srai | inst_slti | inst_sltui | inst_addi
                  | inst_andi | inst_ori | inst_xori;

    wire need_ui5  = inst_slli | inst_srli | inst_srai;
    wire need_si12 = inst_addi | inst_slti | inst_sltui | is_load | is_store;
    wire need_si20 = inst_lu12i | inst_pcadd;
    wire src2_is_4 = inst_jirl | inst_bl;

    assign alu_op[id_pkg::alu_add]  = inst_add | inst_addi | is_load | is_store
                                    | inst_jirl | inst_bl | inst_pcadd;
    assign alu_op[id_pkg::alu_sub]  = inst_sub;
    assign alu_op[id_pkg::alu_slt]  = inst_slt | inst_slti;
    assign alu_op[id_pkg::alu_sltu] = inst_sltu | inst_sltui;
    assign alu_op[id_pkg::alu_and]  = inst_and | inst_andi;
    assign alu_op[id_pkg::alu_nor]  = inst_nor;
    assign alu_op[id_pkg::alu_or]   = inst_or | inst_ori;
    assign alu_op[id_pkg::alu_xor]  = inst_xor | inst_xori;
    assign alu_op[id_pkg::alu_sll]  = inst_sll | inst_slli;
    assign alu_op[id_pkg::alu_srl]  = inst_srl | inst_srli;
    assign alu_op[id_pkg::alu_sra]  = inst_sra | inst_srai;
    assign alu_op[id_pkg::alu_lui]  = inst_lu12i;

    assign mem_op = inst_ld_b  ? id_pkg::mem_ld_b  :
                    inst_ld_h  ? id_pkg::mem_ld_h  :
                    inst_ld_w  ? id_pkg::mem_ld_w  :
                    inst_ld_bu ? id_pkg::mem_ld_bu :
                    inst_ld_hu ? id_pkg::mem_ld_hu :
                    inst_st_b  ? id_pkg::mem_st_b  :
                    inst_st_h  ? id_pkg::mem_st_h  :
                    inst_st_w  ? id_pkg::mem_st_w  : id_pkg::mem_none;

    assign br_kind = inst_beq  ? id_pkg::br_beq  :
                     inst_bne  ? id_pkg::br_bne  :
                     inst_blt  ? id_pkg::br_blt  :
                     inst_bge  ? id_pkg::br_bge  :
                     inst_bltu ? id_pkg::br_bltu :
                     inst_bgeu ? id_pkg::br_bgeu :
                     inst_b    ? id_pkg::br_b    :
                     inst_bl   ? id_pkg::br_bl   :
                     inst_jirl ? id_pkg::br_jirl : id_pkg::br_none;

    assign imm = src2_is_4              ? 32'h4 :
                 need_si20              ? {i20, 12'b0} :
                 (need_ui5 | need_si12) ? {{20{i12[11]}}, i12} :
                                          {20'b0, i12};

    assign br_offs = (inst_b | inst_bl) ? {{4{i26[25]}}, i26, 2'b0}
                                        : {{14{i16[15]}}, i16, 2'b0};

    assign src1_is_pc  = inst_jirl | inst_bl | inst_pcadd;
    assign src2_is_imm = is_ri | is_load | is_store | need_si20 | src2_is_4;
    assign need_r1     = is_3r | is_ri | is_load | is_store | is_cbr | inst_jirl;
    assign need_r2     = is_3r | is_store | is_cbr;
    assign rf_we       = !(is_store | is_cbr | inst_b);
    assign rj          = inst[`ID_RJ_F];
    // branches and stores read rd as second source
    assign raddr2      = (is_cbr | is_store) ? rd : rk;
    assign dest        = inst_bl ? 5'd1 : rd;

    a_alu_onehot: assert property (@(alu_op) $onehot0(alu_op))
        else $error("alu_op not one-hot: %b", alu_op);

endmodule

//--- operand_fetch.sv
`timescale 1ns/1ns
`include "id_macros.svh"

module operand_fetch (
    input  logic              clk,
    input  logic              resetn,
    input  id_pkg::reg_addr_t rj,
    input  id_pkg::reg_addr_t raddr2,
    input  logic              need_r1,
    input  logic              need_r2,
    input  logic              ex_fwd_we,
    input  id_pkg::reg_addr_t ex_fwd_addr,
    input  id_pkg::word_t     ex_fwd_data,
    input  logic              ex_is_load,
    input  logic              mem_fwd_we,
    input  id_pkg::reg_addr_t mem_fwd_addr,
    input  id_pkg::word_t     mem_fwd_data,
    input  logic              wb_we,
    input  id_pkg::reg_addr_t wb_addr,
    input  id_pkg::word_t     wb_data,
    output id_pkg::word_t     rj_value,
    output id_pkg::word_t     rkd_value,
    output logic              stall
);
    id_pkg::word_t rf [`ID_NUM_REGS];
    logic          ex_hit1;
    logic          ex_hit2;

    // r0 is never written, reads of it are forced to zero below
    always_ff @(posedge clk) begin
        if (wb_we && wb_addr != '0) begin
            rf[wb_addr] <= wb_data;
        end
    end

    // youngest producer wins
    function automatic id_pkg::word_t fwd_value(input id_pkg::reg_addr_t addr);
        id_pkg::word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (ex_fwd_we && ex_fwd_addr == addr) begin
            value = ex_fwd_data;
        end else if (mem_fwd_we && mem_fwd_addr == addr) begin
            value = mem_fwd_data;
        end else if (wb_we && wb_addr == addr) begin
            value = wb_data;
        end else begin
            value = rf[addr];
        end
        return value;
    endfunction

    always_comb begin
        rj_value  = fwd_value(rj);
        rkd_value = fwd_value(raddr2);
    end

    // load result not ready until mem stage
    assign ex_hit1 = ex_fwd_we && (ex_fwd_addr == rj) && (rj != '0);
    assign ex_hit2 = ex_fwd_we && (ex_fwd_addr == raddr2) && (raddr2 != '0);
    assign stall   = ex_is_load && ((need_r1 && ex_hit1) || (need_r2 && ex_hit2));

    a_r0_zero: assert property (@(posedge clk) disable iff (!resetn)
        (wb_we && wb_addr == '0) |=>
            (rj != '0 || rj_value == '0) && (raddr2 != '0 || rkd_value == '0))
        else $error("write to r0 leaked into a read");

endmodule

//--- issue_control.sv
`timescale 1ns/1ns
`include "id_macros.svh"

module issue_control (
    input  logic              clk,
    input  logic              resetn,
    input  logic              if_valid,
    input  id_pkg::word_t     if_inst,
    input  id_pkg::word_t     if_pc,
    output logic              id_allowin,
    output id_pkg::word_t     inst,
    output id_pkg::word_t     pc,
    input  id_pkg::alu_op_t   dec_alu_op,
    input  id_pkg::mem_op_t   dec_mem_op,
    input  id_pkg::br_kind_t  br_kind,
    input  logic              src1_is_pc,
    input  logic              src2_is_imm,
    input  logic              dec_rf_we,
    input  id_pkg::reg_addr_t dest,
    input  id_pkg::word_t     imm,
    input  id_pkg::word_t     br_offs,
    input  id_pkg::word_t     rj_value,
    input  id_pkg::word_t     rkd_value,
    input  logic              stall,
    input  logic              ex_allowin,
    output logic              ex_valid,
    output id_pkg::alu_op_t   alu_op,
    output id_pkg::word_t     alu_src1,
    output id_pkg::word_t     alu_src2,
    output logic              rf_we,
    output id_pkg::reg_addr_t rf_waddr,
    output id_pkg::mem_op_t   mem_op,
    output id_pkg::word_t     store_data,
    output logic              br_taken,
    output id_pkg::word_t     br_target
);
    logic valid;
    logic ready_go;
    logic rj_eq;
    logic rj_lt_s;
    logic rj_lt_u;
    logic br_cond;

    assign ready_go   = !stall;
    assign id_allowin = !valid || (ready_go && ex_allowin);
    assign ex_valid   = valid && ready_go;

    // the slot behind a taken branch is wrong-path
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid <= 1'b0;
        end else if (id_allowin) begin
            valid <= if_valid && !br_taken;
        end
    end

    always_ff @(posedge clk) begin
        if (if_valid && id_allowin) begin
            inst <= if_inst;
            pc   <= if_pc;
        end
    end

    assign rj_eq   = (rj_value == rkd_value);
    assign rj_lt_s = ($signed(rj_value) < $signed(rkd_value));
    assign rj_lt_u = (rj_value < rkd_value);

    always_comb begin
        case (br_kind)
            id_pkg::br_beq:  br_cond = rj_eq;
            id_pkg::br_bne:  br_cond = !rj_eq;
            id_pkg::br_blt:  br_cond = rj_lt_s;
            id_pkg::br_bge:  br_cond = !rj_lt_s;
            id_pkg::br_bltu: br_cond = rj_lt_u;
            id_pkg::br_bgeu: br_cond = !rj_lt_u;
            id_pkg::br_b,
            id_pkg::br_bl,
            id_pkg::br_jirl: br_cond = 1'b1;
            default:         br_cond = 1'b0;
        endcase
    end

    assign br_taken  = valid && !stall && br_cond;
    assign br_target = (br_kind == id_pkg::br_jirl) ? rj_value + br_offs : pc + br_offs;

    assign alu_op     = dec_alu_op;
    assign mem_op     = dec_mem_op;
    assign rf_we      = dec_rf_we;
    assign rf_waddr   = dest;
    assign alu_src1   = src1_is_pc ? pc : rj_value;
    assign alu_src2   = src2_is_imm ? imm : rkd_value;
    assign store_data = rkd_value;

    // a stalled instruction stays put and is not offered downstream
    a_stall_hold: assert property (@(posedge clk) disable iff (!resetn)
        (valid && stall) |-> !ex_valid ##1 (valid && $stable(inst) && $stable(pc)))
        else $error("instruction moved during load-use stall");

endmodule

//--- id_stage.sv
`timescale 1ns/1ns
`include "id_macros.svh"

module id_stage (
    input  logic              clk,
    input  logic              resetn,
    // fetch side
    input  logic              if_valid,
    input  id_pkg::word_t     if_inst,
    input  id_pkg::word_t     if_pc,
    output logic              id_allowin,
    output logic              br_taken,
    output id_pkg::word_t     br_target,
    // execute side
    input  logic              ex_allowin,
    output logic              ex_valid,
    output id_pkg::alu_op_t   alu_op,
    output id_pkg::word_t     alu_src1,
    output id_pkg::word_t     alu_src2,
    output logic              rf_we,
    output id_pkg::reg_addr_t rf_waddr,
    output id_pkg::word_t     pc,
    output id_pkg::mem_op_t   mem_op,
    output id_pkg::word_t     store_data,
    // bypass and writeback
    input  logic              ex_fwd_we,
    input  id_pkg::reg_addr_t ex_fwd_addr,
    input  id_pkg::word_t     ex_fwd_data,
    input  logic              ex_is_load,
    input  logic              mem_fwd_we,
    input  id_pkg::reg_addr_t mem_fwd_addr,
    input  id_pkg::word_t     mem_fwd_data,
    input  logic              wb_we,
    input  id_pkg::reg_addr_t wb_addr,
    input  id_pkg::word_t     wb_data
);
    id_pkg::word_t     inst;
    id_pkg::alu_op_t   dec_alu_op;
    id_pkg::mem_op_t   dec_mem_op;
    id_pkg::br_kind_t  br_kind;
    logic              src1_is_pc;
    logic              src2_is_imm;
    logic              need_r1;
    logic              need_r2;
    logic              dec_rf_we;
    id_pkg::reg_addr_t rj;
    id_pkg::reg_addr_t raddr2;
    id_pkg::reg_addr_t dest;
    id_pkg::word_t     imm;
    id_pkg::word_t     br_offs;
    id_pkg::word_t     rj_value;
    id_pkg::word_t     rkd_value;
    logic              stall;

    inst_decoder inst_decoder_i (
        .inst        (inst),
        .alu_op      (dec_alu_op),
        .mem_op      (dec_mem_op),
        .br_kind     (br_kind),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .need_r1     (need_r1),
        .need_r2     (need_r2),
        .rf_we       (dec_rf_we),
        .rj          (rj),
        .raddr2      (raddr2),
        .dest        (dest),
        .imm         (imm),
        .br_offs     (br_offs)
    );

    operand_fetch operand_fetch_i (
        .clk          (clk),
        .resetn       (resetn),
        .rj           (rj),
        .raddr2       (raddr2),
        .need_r1      (need_r1),
        .need_r2      (need_r2),
        .ex_fwd_we    (ex_fwd_we),
        .ex_fwd_addr  (ex_fwd_addr),
        .ex_fwd_data  (ex_fwd_data),
        .ex_is_load   (ex_is_load),
        .mem_fwd_we   (mem_fwd_we),
        .mem_fwd_addr (mem_fwd_addr),
        .mem_fwd_data (mem_fwd_data),
        .wb_we        (wb_we),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .rj_value     (rj_value),
        .rkd_value    (rkd_value),
        .stall        (stall)
    );

    issue_control issue_control_i (
        .clk         (clk),
        .resetn      (resetn),
        .if_valid    (if_valid),
        .if_inst     (if_inst),
        .if_pc       (if_pc),
        .id_allowin  (id_allowin),
        .inst        (inst),
        .pc          (pc),
        .dec_alu_op  (dec_alu_op),
        .dec_mem_op  (dec_mem_op),
        .br_kind     (br_kind),
        .src1_is_pc  (src1_is_pc),
        .src2_is_imm (src2_is_imm),
        .dec_rf_we   (dec_rf_we),
        .dest        (dest),
        .imm         (imm),
        .br_offs     (br_offs),
        .rj_value    (rj_value),
        .rkd_value   (rkd_value),
        .stall       (stall),
        .ex_allowin  (ex_allowin),
        .ex_valid    (ex_valid),
        .alu_op      (alu_op),
        .alu_src1    (alu_src1),
        .alu_src2    (alu_src2),
        .rf_we       (rf_we),
        .rf_waddr    (rf_waddr),
        .mem_op      (mem_op),
        .store_data  (store_data),
        .br_taken    (br_taken),
        .br_target   (br_target)
    );

endmodule

//--- id_ref_model.svh
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// shadow of the register file, loaded through the writeback port
logic [31:0] shadow_rf [32];

function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
endfunction

function automatic logic [31:0] enc_3r(input logic [4:0] f, input logic [4:0] rd,
                                       input logic [4:0] rj, input logic [4:0] rk);
    return {6'h00, 4'h0, 2'h1, f, rk, rj, rd};
endfunction

function automatic logic [31:0] enc_shi(input logic [4:0] f, input logic [4:0] rd,
                                        input logic [4:0] rj, input logic [4:0] ui5);
    return {6'h00, 4'h1, 2'h0, f, ui5, rj, rd};
endfunction

// 2ri12 format: arithmetic immediates and memory ops
function automatic logic [31:0] enc_2ri(input logic [5:0] op6, input logic [3:0] op4,
                                        input logic [4:0] rd, input logic [4:0] rj,
                                        input logic [11:0] i12);
    return {op6, op4, i12, rj, rd};
endfunction

function automatic logic [31:0] enc_br26(input logic [5:0] op6, input logic [25:0] o26);
    return {op6, o26[15:0], o26[25:16]};
endfunction

// operand as the stage should see it, youngest producer first
function automatic logic [31:0] read_model(input logic [4:0] a);
    if (a == 5'd0)
        return 32'd0;
    if (ex_fwd_we && ex_fwd_addr == a)
        return ex_fwd_data;
    if (mem_fwd_we && mem_fwd_addr == a)
        return mem_fwd_data;
    if (wb_we && wb_addr == a)
        return wb_data;
    return shadow_rf[a];
endfunction

// kind order: jirl, b, bl, beq, bne, blt, bge, bltu, bgeu
function automatic logic branch_model(input int k, input logic [31:0] a, input logic [31:0] b);
    case (k)
        3: return a == b;
        4: return a != b;
        5: return $signed(a) < $signed(b);
        6: return $signed(a) >= $signed(b);
        7: return a < b;
        8: return a >= b;
        default: return 1'b1;
    endcase
endfunction

`endif

//--- id_stage_tb.sv
`timescale 1ns/1ns
`include "id_macros.svh"

module id_stage_tb;
    logic              clk;
    logic              resetn;
    logic              if_valid;
    id_pkg::word_t     if_inst;
    id_pkg::word_t     if_pc;
    logic              id_allowin;
    logic              br_taken;
    id_pkg::word_t     br_target;
    logic              ex_allowin;
    logic              ex_valid;
    id_pkg::alu_op_t   alu_op;
    id_pkg::word_t     alu_src1;
    id_pkg::word_t     alu_src2;
    logic              rf_we;
    id_pkg::reg_addr_t rf_waddr;
    id_pkg::word_t     pc;
    id_pkg::mem_op_t   mem_op;
    id_pkg::word_t     store_data;
    logic              ex_fwd_we;
    id_pkg::reg_addr_t ex_fwd_addr;
    id_pkg::word_t     ex_fwd_data;
    logic              ex_is_load;
    logic              mem_fwd_we;
    id_pkg::reg_addr_t mem_fwd_addr;
    id_pkg::word_t     mem_fwd_data;
    logic              wb_we;
    id_pkg::reg_addr_t wb_addr;
    id_pkg::word_t     wb_data;

    `include "id_ref_model.svh"

    localparam logic [4:0] fn_3r [0:10] = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09,
                                            5'h0a, 5'h0b, 5'h0e, 5'h0f, 5'h10};
    localparam int         bit_3r [0:10] = '{0, 1, 2, 3, 5, 4, 6, 7, 8, 9, 10};
    localparam logic [4:0] fn_sh [0:2] = '{5'h01, 5'h09, 5'h11};
    localparam logic [3:0] op_ri [0:5] = '{4'h8, 4'h9, 4'ha, 4'hd, 4'he, 4'hf};
    localparam int         bit_ri [0:5] = '{2, 3, 0, 4, 6, 7};
    localparam logic [3:0] op_mem [0:7] = '{4'h0, 4'h1, 4'h2, 4'h8, 4'h9, 4'h4, 4'h5, 4'h6};

    logic [31:0] seed = 32'h1bac_bba2;
    int          errors = 0;

    id_stage id_stage_i (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] rand_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic end_run();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, exp, got);
        end
    endtask

    task automatic timed_out(input string what);
        errors++;
        $display("timeout while waiting for %s", what);
    endtask

    // hold the instruction on the fetch side until the stage takes it
    task automatic issue(input logic [31:0] i, input logic [31:0] p);
        int n;
        n = 0;
        @(posedge clk);
        if_valid <= 1'b1;
        if_inst  <= i;
        if_pc    <= p;
        do begin
            @(negedge clk);
            n++;
        end while (!id_allowin && n < 50);
        if (!id_allowin)
            timed_out("id_allowin");
        @(posedge clk);
        if_valid <= 1'b0;
    endtask

    task automatic wait_ex_valid();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!ex_valid && n < 50);
        if (!ex_valid)
            timed_out("ex_valid");
    endtask

    initial begin
        logic [31:0] inst;
        logic [31:0] p;
        logic [31:0] r;
        logic [31:0] exp2;
        logic [31:0] d;
        logic [31:0] hold [4];
        logic [4:0]  rd;
        logic [4:0]  rj;
        logic [4:0]  rk;
        int          k;
        int          bit_i;

        clk = 0;
        resetn = 0;
        if_valid = 0;
        if_inst = '0;
        if_pc = '0;
        ex_allowin = 1;
        ex_fwd_we = 0;
        ex_fwd_addr = '0;
        ex_fwd_data = '0;
        ex_is_load = 0;
        mem_fwd_we = 0;
        mem_fwd_addr = '0;
        mem_fwd_data = '0;
        wb_we = 0;
        wb_addr = '0;
        wb_data = '0;
        shadow_rf[0] = '0;
        repeat (10) @(posedge clk);
        resetn <= 1'b1;
        @(negedge clk);
        check("reset ex_valid", 0, 32'(ex_valid));
        check("reset br_taken", 0, 32'(br_taken));
        check("reset id_allowin", 1, 32'(id_allowin));

        // r0 gets a write too and must keep reading zero
        for (int a = 0; a < 32; a++) begin
            @(posedge clk);
            d = rand_next();
            wb_we <= 1'b1;
            wb_addr <= 5'(a);
            wb_data <= d;
            if (a != 0)
                shadow_rf[a] = d;
        end
        @(posedge clk);
        wb_we <= 1'b0;

        // ALU, shift, immediate, lu12i and pcaddu12i
        for (int t = 0; t < 60; t++) begin
            r = rand_next();
            rd = r[4:0];
            rj = (t % 8 == 0) ? 5'd0 : r[9:5];
            rk = r[14:10];
            k = int'(r[31:16] % 22);
            p = rand_next() & ~32'h3;
            if (k < 11) begin
                inst = enc_3r(fn_3r[k], rd, rj, rk);
                bit_i = bit_3r[k];
                exp2 = read_model(rk);
            end else if (k < 14) begin
                inst = enc_shi(fn_sh[k-11], rd, rj, rk);
                bit_i = 8 + k - 11;
                exp2 = sext12(inst[21:10]);
            end else if (k < 20) begin
                inst = enc_2ri(6'h00, op_ri[k-14], rd, rj, r[26:15]);
                bit_i = bit_ri[k-14];
                exp2 = (k < 17) ? sext12(r[26:15]) : {20'd0, r[26:15]};
            end else begin
                inst = {(k == 20) ? 6'h05 : 6'h07, 1'b0, r[29:10], rd};
                bit_i = (k == 20) ? 11 : 0;
                exp2 = {r[29:10], 12'd0};
            end
            issue(inst, p);
            wait_ex_valid();
            check("alu alu_op", 32'(12'd1 << bit_i), 32'(alu_op));
            check("alu src1", (k == 21) ? p : read_model(inst[9:5]), alu_src1);
            check("alu src2", exp2, alu_src2);
            check("alu rf_we", 1, 32'(rf_we));
            check("alu rf_waddr", 32'(rd), 32'(rf_waddr));
            check("alu pc", p, pc);
        end

        // op_mem lists loads then stores in mem_op_t order
        for (int t = 0; t < 30; t++) begin
            r = rand_next();
            k = int'(r[31:16] % 8);
            inst = enc_2ri(6'h0a, op_mem[k], r[4:0], r[9:5], r[21:10]);
            issue(inst, rand_next() & ~32'h3);
            wait_ex_valid();
            check("mem mem_op", 32'(k + 1), 32'(mem_op));
            check("mem src1", read_model(r[9:5]), alu_src1);
            check("mem src2", sext12(r[21:10]), alu_src2);
            check("mem rf_we", (k < 5) ? 1 : 0, 32'(rf_we));
            if (k >= 5)
                check("mem store_data", read_model(r[4:0]), store_data);
        end

        // overlapping producers on one register
        for (int t = 0; t < 30; t++) begin
            r = rand_next();
            rj = 5'd1 + 5'(r[7:0] % 31);
            @(posedge clk);
            ex_fwd_we <= r[8];
            mem_fwd_we <= r[9];
            wb_we <= r[10];
            ex_fwd_addr <= rj;
            mem_fwd_addr <= rj;
            wb_addr <= rj;
            ex_fwd_data <= rand_next();
            mem_fwd_data <= rand_next();
            wb_data <= rand_next();
            issue(enc_3r(5'h00, r[15:11], rj, r[20:16]), 32'h1c00_0000);
            wait_ex_valid();
            check("fwd src1", read_model(rj), alu_src1);
            check("fwd src2", read_model(r[20:16]), alu_src2);
            if (wb_we)
                shadow_rf[rj] = wb_data;
            @(posedge clk);
            ex_fwd_we <= 1'b0;
            mem_fwd_we <= 1'b0;
            wb_we <= 1'b0;
        end

        // load-use hazard on rj
        for (int t = 0; t < 12; t++) begin
            r = rand_next();
            rj = 5'd1 + 5'(r[7:0] % 31);
            d = rand_next();
            @(posedge clk);
            ex_fwd_we <= 1'b1;
            ex_fwd_addr <= rj;
            ex_fwd_data <= d;
            ex_is_load <= 1'b1;
            issue(enc_3r(5'h00, r[15:11], rj, r[20:16]), 32'h1c00_0100);
            repeat (1 + int'(r[31:30])) begin
                @(negedge clk);
                check("stall ex_valid", 0, 32'(ex_valid));
                check("stall id_allowin", 0, 32'(id_allowin));
            end
            @(posedge clk);
            ex_is_load <= 1'b0;
            wait_ex_valid();
            check("stall fwd src1", d, alu_src1);
            @(posedge clk);
            ex_fwd_we <= 1'b0;
        end

        // branches held by back-pressure
        for (int t = 0; t < 40; t++) begin
            r = rand_next();
            k = int'(r[31:16] % 9);
            rj = r[4:0];
            rd = r[5] ? rj : r[10:6];
            p = rand_next() & ~32'h3;
            inst = (k == 1 || k == 2) ? enc_br26(6'h13 + 6'(k), 26'(rand_next()))
                                      : {6'h13 + 6'(k), r[26:11], rj, rd};
            @(posedge clk);
            ex_allowin <= 1'b0;
            issue(inst, p);
            wait_ex_valid();
            if (k == 0)
                d = read_model(inst[9:5]) + {{14{inst[25]}}, inst[25:10], 2'b0};
            else if (k < 3)
                d = p + {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};
            else
                d = p + {{14{inst[25]}}, inst[25:10], 2'b0};
            check("br taken", 32'(branch_model(k, read_model(inst[9:5]),
                  read_model(inst[4:0]))), 32'(br_taken));
            check("br target", d, br_target);
            check("br rf_we", (k == 0 || k == 2) ? 1 : 0, 32'(rf_we));
            if (k == 2)
                check("bl rf_waddr", 1, 32'(rf_waddr));
            hold = '{alu_src1, alu_src2, br_target, 32'(br_taken)};
            repeat (3) begin
                @(negedge clk);
                check("hold src1", hold[0], alu_src1);
                check("hold src2", hold[1], alu_src2);
                check("hold target", hold[2], br_target);
                check("hold taken", hold[3], 32'(br_taken));
                check("hold ex_valid", 1, 32'(ex_valid));
                check("hold id_allowin", 0, 32'(id_allowin));
            end
            @(posedge clk);
            ex_allowin <= 1'b1;
            @(negedge clk);
            check("deliver ex_valid", 1, 32'(ex_valid));
            check("deliver id_allowin", 1, 32'(id_allowin));
        end
        @(posedge clk);
        end_run();
    end

endmodule

//--- flist.f
+incdir+.
id_pkg.sv
inst_decoder.sv
operand_fetch.sv
issue_control.sv
id_stage.sv
id_stage_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the decode-stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module id_stage_tb -o sim_id_stage \
    && ./obj_dir/sim_id_stage > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "PASS: all tests" sim.log && echo "simulation passed" || exit 1
